/* source/aplic_pkg.sv */
package aplic_pkg;

  // Bus and field widths
  localparam int DATA_W = 32;
  localparam int SRC_W  = 5;
  localparam int PRIO_W = 8;
  localparam int HART_W = 14;

  // Domain 0 is M, domain 1 is S
  localparam int NR_DOM = 2;
  typedef logic dom_t;

  // ============================================================
  // Register offsets inside one domain window
  // ============================================================
  localparam logic [15:0] OFF_DOMAINCFG = 16'h0000;
  localparam logic [15:0] OFF_SOURCECFG = 16'h0004;
  localparam logic [15:0] OFF_SETIP     = 16'h1C00;
  localparam logic [15:0] OFF_SETIPNUM  = 16'h1CDC;
  localparam logic [15:0] OFF_IN_CLRIP  = 16'h1D00;
  localparam logic [15:0] OFF_CLRIPNUM  = 16'h1DDC;
  localparam logic [15:0] OFF_SETIE     = 16'h1E00;
  localparam logic [15:0] OFF_SETIENUM  = 16'h1EDC;
  localparam logic [15:0] OFF_CLRIE     = 16'h1F00;
  localparam logic [15:0] OFF_CLRIENUM  = 16'h1FDC;
  localparam logic [15:0] OFF_TARGET    = 16'h3004;

  // ============================================================
  // Source modes in sourcecfg[2:0]
  // ============================================================
  localparam logic [2:0] SM_INACTIVE = 3'd0;
  localparam logic [2:0] SM_DETACHED = 3'd1;
  localparam logic [2:0] SM_EDGE1    = 3'd4;
  localparam logic [2:0] SM_EDGE0    = 3'd5;
  localparam logic [2:0] SM_LEVEL1   = 3'd6;
  localparam logic [2:0] SM_LEVEL0   = 3'd7;

  // Read-only top byte of domaincfg
  localparam logic [7:0] DOMAINCFG_FIXED = 8'h80;

endpackage

/* source/aplic_wb_port.sv */
`timescale 1ns/1ns

module aplic_wb_port
  import aplic_pkg::*;
#(
  parameter logic [DATA_W-1:0] BASE_M = 32'h0C00_0000,
  parameter logic [DATA_W-1:0] BASE_S = 32'h0D00_0000
) (
  input  logic              i_clk,
  input  logic              ni_rst,
  // Wishbone classic slave
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  logic [DATA_W-1:0] i_wb_adr,
  input  logic [DATA_W-1:0] i_wb_dat,
  output logic [DATA_W-1:0] o_wb_dat,
  output logic              o_wb_ack,
  // Read words from the register modules
  input  logic [DATA_W-1:0] i_rd_cfg,
  input  logic [DATA_W-1:0] i_rd_pe,
  // Access towards the register modules
  output logic              o_acc,
  output logic              o_we,
  output dom_t              o_dom,
  output logic [13:0]       o_off,
  output logic [DATA_W-1:0] o_wdat
);

  // Each domain window spans 16 KiB
  localparam int WIN_LSB = 14;

  logic hit_m;
  logic hit_s;
  logic hit;
  logic take;
  logic ack_q;

  // ============================================================
  // Window decode
  // ============================================================
  assign hit_m = (i_wb_adr[DATA_W-1:WIN_LSB] == BASE_M[DATA_W-1:WIN_LSB]);
  assign hit_s = (i_wb_adr[DATA_W-1:WIN_LSB] == BASE_S[DATA_W-1:WIN_LSB]);
  assign hit   = hit_m | hit_s;

  assign o_dom  = dom_t'(hit_s);
  assign o_off  = i_wb_adr[WIN_LSB-1:0];
  assign o_we   = i_wb_we;
  assign o_wdat = i_wb_dat;

  // ============================================================
  // Handshake
  // ============================================================
  // Accept once, then the ack cycle blocks a second acceptance
  assign take = i_wb_cyc & i_wb_stb & ~ack_q;

  // Misses are acknowledged but never reach the registers
  assign o_acc = take & hit;

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take;
    end
  end

  assign o_wb_ack = ack_q;

  // Read data lines up with the ack
  always_ff @(posedge i_clk) begin
    if (take) begin
      if (!i_wb_we && hit) begin
        o_wb_dat <= i_rd_cfg | i_rd_pe;
      end else begin
        o_wb_dat <= '0;
      end
    end
  end

endmodule

/* source/aplic_config_regs.sv */
`timescale 1ns/1ns

module aplic_config_regs
  import aplic_pkg::*;
#(
  parameter int NR_SRC = 32
) (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  input  logic                           i_acc,
  input  logic                           i_we,
  input  dom_t                           i_dom,
  input  logic [13:0]                    i_off,
  input  logic [DATA_W-1:0]              i_wdat,
  output logic [DATA_W-1:0]              o_rd,
  output logic [NR_SRC-1:0]              o_owner,
  output logic [NR_SRC-1:0]              o_active,
  output logic [NR_SRC-1:0][PRIO_W-1:0]  o_prio,
  output logic [NR_DOM-1:0]              o_ie
);

  localparam int DELEG_BIT = 10;
  localparam int IE_BIT    = 8;
  localparam int RSVD_W    = DATA_W - HART_W - PRIO_W;

  logic [15:0]                    off;
  logic                           wr;
  logic [2:0]                     new_mode;
  logic [NR_DOM-1:0]              ie_q;
  logic [NR_SRC-1:0]              owner_q;
  logic [NR_SRC-1:0][2:0]         mode_q;
  logic [NR_SRC-1:0][HART_W-1:0]  hart_q;
  logic [NR_SRC-1:0][PRIO_W-1:0]  prio_q;
  logic [NR_SRC-1:0]              active;
  logic [NR_SRC-1:0]              cfg_sel;
  logic [NR_SRC-1:0]              tgt_sel;

  // Modes 2 and 3 are reserved
  function automatic logic [2:0] legal_mode(input logic [2:0] mode);
    case (mode)
      SM_DETACHED, SM_EDGE1, SM_EDGE0, SM_LEVEL1, SM_LEVEL0: legal_mode = mode;
      default: legal_mode = SM_INACTIVE;
    endcase
  endfunction

  assign off      = {2'b00, i_off};
  assign wr       = i_acc & i_we;
  assign new_mode = i_wdat[DELEG_BIT] ? SM_INACTIVE : legal_mode(i_wdat[2:0]);

  // One sourcecfg and one target word per source, starting at source 1
  always_comb begin
    cfg_sel = '0;
    tgt_sel = '0;
    for (int n = 1; n < NR_SRC; n++) begin
      cfg_sel[n] = (off == OFF_SOURCECFG + 16'(4 * (n - 1)));
      tgt_sel[n] = (off == OFF_TARGET + 16'(4 * (n - 1)));
    end
  end

  always_comb begin
    for (int n = 0; n < NR_SRC; n++) begin
      active[n] = (mode_q[n] != SM_INACTIVE);
    end
  end

  // ============================================================
  // domaincfg, only IE is kept
  // ============================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ie_q <= '0;
    end else if (wr && off == OFF_DOMAINCFG) begin
      ie_q[i_dom] <= i_wdat[IE_BIT];
    end
  end

  // ============================================================
  // sourcecfg and delegation
  // ============================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      owner_q <= '0;
      mode_q  <= '0;
    end else if (wr) begin
      for (int n = 1; n < NR_SRC; n++) begin
        if (cfg_sel[n]) begin
          if (i_dom == 1'b0) begin
            // M moves the source between domains
            owner_q[n] <= i_wdat[DELEG_BIT];
            mode_q[n]  <= new_mode;
          end else if (owner_q[n]) begin
            mode_q[n] <= new_mode;
          end
        end
      end
    end
  end

  // ============================================================
  // target, direct mode format
  // ============================================================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      hart_q <= '0;
      prio_q <= '0;
    end else if (wr) begin
      for (int n = 1; n < NR_SRC; n++) begin
        if (tgt_sel[n] && owner_q[n] == i_dom && active[n]) begin
          hart_q[n] <= i_wdat[DATA_W-1 -: HART_W];
          // Priority 0 is not allowed
          prio_q[n] <= (i_wdat[PRIO_W-1:0] == '0) ? PRIO_W'(1) : i_wdat[PRIO_W-1:0];
        end
      end
    end
  end

  // Read side
  always_comb begin
    o_rd = '0;
    if (off == OFF_DOMAINCFG) begin
      o_rd = {DOMAINCFG_FIXED, 15'b0, ie_q[i_dom], 8'b0};
    end
    for (int n = 1; n < NR_SRC; n++) begin
      if (cfg_sel[n]) begin
        if (i_dom == 1'b0) begin
          o_rd = owner_q[n] ? (DATA_W'(1) << DELEG_BIT) : DATA_W'(mode_q[n]);
        end else if (owner_q[n]) begin
          o_rd = DATA_W'(mode_q[n]);
        end
      end
      if (tgt_sel[n] && owner_q[n] == i_dom) begin
        o_rd = {hart_q[n], {RSVD_W{1'b0}}, prio_q[n]};
      end
    end
  end

  assign o_owner  = owner_q;
  assign o_active = active;
  assign o_prio   = prio_q;
  assign o_ie     = ie_q;

endmodule

/* source/aplic_pend_enable.sv */
`timescale 1ns/1ns

module aplic_pend_enable
  import aplic_pkg::*;
#(
  parameter int NR_SRC = 32
) (
  input  logic              i_clk,
  input  logic              ni_rst,
  input  logic              i_acc,
  input  logic              i_we,
  input  dom_t              i_dom,
  input  logic [13:0]       i_off,
  input  logic [DATA_W-1:0] i_wdat,
  input  logic [NR_SRC-1:0] i_owner,
  input  logic [NR_SRC-1:0] i_active,
  input  logic [NR_SRC-1:0] i_src_pulse,
  output logic [DATA_W-1:0] o_rd,
  output logic [NR_SRC-1:0] o_pending,
  output logic [NR_SRC-1:0] o_enable
);

  logic [15:0]       off;
  logic              wr;
  logic [NR_SRC-1:0] dom_mask;
  logic [NR_SRC-1:0] vec;
  logic [NR_SRC-1:0] num_vec;
  logic [NR_SRC-1:0] pend_q;
  logic [NR_SRC-1:0] pend_d;
  logic [NR_SRC-1:0] en_q;
  logic [NR_SRC-1:0] en_d;

  assign off = {2'b00, i_off};
  assign wr  = i_acc & i_we;

  // Sources visible to the accessing domain
  assign dom_mask = (i_dom == 1'b1) ? i_owner : ~i_owner;

  // ============================================================
  // Write operands
  // ============================================================
  assign vec = i_wdat[NR_SRC-1:0] & dom_mask;

  // Number writes become a one-hot vector, out of range numbers do nothing
  always_comb begin
    num_vec = '0;
    if (i_wdat < DATA_W'(NR_SRC)) begin
      num_vec[i_wdat[SRC_W-1:0]] = 1'b1;
    end
    num_vec = num_vec & dom_mask;
  end

  // ============================================================
  // Next state
  // ============================================================
  always_comb begin
    // Gateway pulses first, a clear in the same cycle wins
    pend_d = pend_q | i_src_pulse;
    en_d   = en_q;
    if (wr) begin
      case (off)
        OFF_SETIP:    pend_d = pend_d | vec;
        OFF_SETIPNUM: pend_d = pend_d | num_vec;
        OFF_IN_CLRIP: pend_d = pend_d & ~vec;
        OFF_CLRIPNUM: pend_d = pend_d & ~num_vec;
        OFF_SETIE:    en_d   = en_q | vec;
        OFF_SETIENUM: en_d   = en_q | num_vec;
        OFF_CLRIE:    en_d   = en_q & ~vec;
        OFF_CLRIENUM: en_d   = en_q & ~num_vec;
        default: ;
      endcase
    end
    // Inactive sources hold nothing, source 0 does not exist
    pend_d    = pend_d & i_active;
    en_d      = en_d & i_active;
    pend_d[0] = 1'b0;
    en_d[0]   = 1'b0;
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      pend_q <= pend_d;
      en_q   <= en_d;
    end
  end

  // ============================================================
  // Read side
  // ============================================================
  // in_clrip shows pending; clrie and the number registers read 0
  always_comb begin
    case (off)
      OFF_SETIP, OFF_IN_CLRIP: o_rd = DATA_W'(pend_q & dom_mask);
      OFF_SETIE:               o_rd = DATA_W'(en_q & dom_mask);
      default:                 o_rd = '0;
    endcase
  end

  assign o_pending = pend_q;
  assign o_enable  = en_q;

endmodule

/* source/aplic_top_select.sv */
`timescale 1ns/1ns

module aplic_top_select
  import aplic_pkg::*;
#(
  parameter int NR_SRC = 32
) (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  input  logic [NR_SRC-1:0]              i_owner,
  input  logic [NR_SRC-1:0]              i_pending,
  input  logic [NR_SRC-1:0]              i_enable,
  input  logic [NR_SRC-1:0][PRIO_W-1:0]  i_prio,
  input  logic [NR_DOM-1:0]              i_ie,
  output logic [NR_DOM-1:0][SRC_W-1:0]   o_top_id,
  output logic [NR_DOM-1:0][PRIO_W-1:0]  o_top_prio
);

  logic [NR_DOM-1:0][SRC_W-1:0]  best_id;
  logic [NR_DOM-1:0][PRIO_W-1:0] best_prio;

  // Smallest priority number wins, ascending scan keeps the lower id on a tie
  always_comb begin
    best_id   = '0;
    best_prio = '0;
    for (int d = 0; d < NR_DOM; d++) begin
      for (int n = 1; n < NR_SRC; n++) begin
        if (i_owner[n] == dom_t'(d) && i_pending[n] && i_enable[n] &&
            (best_id[d] == '0 || i_prio[n] < best_prio[d])) begin
          best_id[d]   = SRC_W'(n);
          best_prio[d] = i_prio[n];
        end
      end
      // Domain delivery switched off
      if (!i_ie[d]) begin
        best_id[d]   = '0;
        best_prio[d] = '0;
      end
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      o_top_id   <= '0;
      o_top_prio <= '0;
    end else begin
      o_top_id   <= best_id;
      o_top_prio <= best_prio;
    end
  end

endmodule

/* source/aplic_domain_top.sv */
`timescale 1ns/1ns

module aplic_domain_top
  import aplic_pkg::*;
#(
  parameter int                NR_SRC = 32,
  parameter logic [DATA_W-1:0] BASE_M = 32'h0C00_0000,
  parameter logic [DATA_W-1:0] BASE_S = 32'h0D00_0000
) (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [DATA_W-1:0]              i_wb_adr,
  input  logic [DATA_W-1:0]              i_wb_dat,
  output logic [DATA_W-1:0]              o_wb_dat,
  output logic                           o_wb_ack,
  input  logic [NR_SRC-1:0]              i_src_pulse,
  output logic [NR_DOM-1:0][SRC_W-1:0]   o_top_id,
  output logic [NR_DOM-1:0][PRIO_W-1:0]  o_top_prio
);

  // Access from the port
  logic              acc;
  logic              we;
  dom_t              dom;
  logic [13:0]       off;
  logic [DATA_W-1:0] wdat;
  logic [DATA_W-1:0] rd_cfg;
  logic [DATA_W-1:0] rd_pe;

  // Shared source state
  logic [NR_SRC-1:0]             owner;
  logic [NR_SRC-1:0]             active;
  logic [NR_SRC-1:0][PRIO_W-1:0] prio;
  logic [NR_DOM-1:0]             ie;
  logic [NR_SRC-1:0]             pending;
  logic [NR_SRC-1:0]             enable;

  aplic_wb_port #(
    .BASE_M (BASE_M),
    .BASE_S (BASE_S)
  ) wb_port_inst (
    .i_clk    (i_clk),
    .ni_rst   (ni_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .i_rd_cfg (rd_cfg),
    .i_rd_pe  (rd_pe),
    .o_acc    (acc),
    .o_we     (we),
    .o_dom    (dom),
    .o_off    (off),
    .o_wdat   (wdat)
  );

  aplic_config_regs #(
    .NR_SRC (NR_SRC)
  ) config_regs_inst (
    .i_clk    (i_clk),
    .ni_rst   (ni_rst),
    .i_acc    (acc),
    .i_we     (we),
    .i_dom    (dom),
    .i_off    (off),
    .i_wdat   (wdat),
    .o_rd     (rd_cfg),
    .o_owner  (owner),
    .o_active (active),
    .o_prio   (prio),
    .o_ie     (ie)
  );

  aplic_pend_enable #(
    .NR_SRC (NR_SRC)
  ) pend_enable_inst (
    .i_clk       (i_clk),
    .ni_rst      (ni_rst),
    .i_acc       (acc),
    .i_we        (we),
    .i_dom       (dom),
    .i_off       (off),
    .i_wdat      (wdat),
    .i_owner     (owner),
    .i_active    (active),
    .i_src_pulse (i_src_pulse),
    .o_rd        (rd_pe),
    .o_pending   (pending),
    .o_enable    (enable)
  );

  aplic_top_select #(
    .NR_SRC (NR_SRC)
  ) top_select_inst (
    .i_clk      (i_clk),
    .ni_rst     (ni_rst),
    .i_owner    (owner),
    .i_pending  (pending),
    .i_enable   (enable),
    .i_prio     (prio),
    .i_ie       (ie),
    .o_top_id   (o_top_id),
    .o_top_prio (o_top_prio)
  );

endmodule

/* verif/aplic_asserts.sv */
`timescale 1ns/1ns

module aplic_asserts (
  input logic i_clk,
  input logic ni_rst,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic o_wb_ack
);

  // Ack answers a request seen on the edge before
  ack_follows_stb: assert property (
    @(posedge i_clk) disable iff (!ni_rst) o_wb_ack |-> $past(i_wb_cyc && i_wb_stb)
  ) else $error("o_wb_ack raised without a preceding strobe");

  // One ack per access
  ack_single_cycle: assert property (
    @(posedge i_clk) disable iff (!ni_rst) o_wb_ack |=> !o_wb_ack
  ) else $error("o_wb_ack held high for two cycles");

  ack_low_in_reset: assert property (
    @(posedge i_clk) !ni_rst |-> !o_wb_ack
  ) else $error("o_wb_ack high while reset is asserted");

endmodule

bind aplic_wb_port aplic_asserts wb_asserts_inst (
  .i_clk    (i_clk),
  .ni_rst   (ni_rst),
  .i_wb_cyc (i_wb_cyc),
  .i_wb_stb (i_wb_stb),
  .o_wb_ack (o_wb_ack)
);

/* verif/aplic_tb.sv */
`timescale 1ns/1ns

module aplic_tb
  import aplic_pkg::*;
();

  localparam int                NR_SRC    = 32;
  localparam logic [DATA_W-1:0] BASE_M    = 32'h0C00_0000;
  localparam logic [DATA_W-1:0] BASE_S    = 32'h0D00_0000;
  localparam logic [DATA_W-1:0] UNMAPPED  = 32'h0E00_0000;
  localparam int                ACK_LIMIT = 16;

  // Number variants of the pending and enable registers sit at odd indices
  localparam logic [15:0] PE_OFF [8] = '{OFF_SETIP, OFF_SETIPNUM, OFF_IN_CLRIP, OFF_CLRIPNUM,
                                         OFF_SETIE, OFF_SETIENUM, OFF_CLRIE, OFF_CLRIENUM};

  logic                          i_clk;
  logic                          ni_rst;
  logic                          i_wb_cyc;
  logic                          i_wb_stb;
  logic                          i_wb_we;
  logic [DATA_W-1:0]             i_wb_adr;
  logic [DATA_W-1:0]             i_wb_dat;
  logic [DATA_W-1:0]             o_wb_dat;
  logic                          o_wb_ack;
  logic [NR_SRC-1:0]             i_src_pulse;
  logic [NR_DOM-1:0][SRC_W-1:0]  o_top_id;
  logic [NR_DOM-1:0][PRIO_W-1:0] o_top_prio;

  // Shadow copy of the register state
  logic [NR_SRC-1:0] m_owner;
  logic [NR_SRC-1:0] m_pend;
  logic [NR_SRC-1:0] m_en;
  logic [NR_DOM-1:0] m_ie;
  logic [2:0]        m_mode [NR_SRC];
  logic [7:0]        m_prio [NR_SRC];
  logic [13:0]       m_hart [NR_SRC];

  // Checks waiting for the compare process
  string             name_q [$];
  logic [DATA_W-1:0] got_q [$];
  logic [DATA_W-1:0] want_q [$];

  integer seed;
  int     checks;
  int     errors;
  int     timeouts;
  int     test_checks;
  int     test_errors;

  aplic_domain_top #(
    .NR_SRC (NR_SRC),
    .BASE_M (BASE_M),
    .BASE_S (BASE_S)
  ) aplic_domain_top_inst (
    .i_clk       (i_clk),
    .ni_rst      (ni_rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_src_pulse (i_src_pulse),
    .o_top_id    (o_top_id),
    .o_top_prio  (o_top_prio)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ============================================================
  // Reference model
  // ============================================================
  function automatic logic [31:0] owned_by(input logic dom);
    return dom ? m_owner : ~m_owner;
  endfunction

  // Delegation and reserved modes both leave the source inactive
  function automatic logic [2:0] filter_mode(input logic [31:0] d);
    if (d[10] || d[2:0] == 3'd2 || d[2:0] == 3'd3) return SM_INACTIVE;
    return d[2:0];
  endfunction

  function automatic logic [31:0] num_bit(input logic dom, input logic [31:0] d);
    logic [31:0] v;
    v = '0;
    if (d < 32'(NR_SRC)) v[d[4:0]] = 1'b1;
    return v & owned_by(dom);
  endfunction

  function automatic void drop_inactive();
    for (int n = 0; n < NR_SRC; n++) begin
      if (m_mode[n] == SM_INACTIVE) begin
        m_pend[n] = 1'b0;
        m_en[n]   = 1'b0;
      end
    end
  endfunction

  function automatic bit is_cfg(input logic [15:0] off);
    return off >= OFF_SOURCECFG && off < OFF_SOURCECFG + 16'(4 * (NR_SRC - 1));
  endfunction

  function automatic bit is_tgt(input logic [15:0] off);
    return off >= OFF_TARGET && off < OFF_TARGET + 16'(4 * (NR_SRC - 1));
  endfunction

  function automatic void model_write(input logic dom, input logic [15:0] off,
                                      input logic [31:0] d);
    int          n;
    logic [31:0] vec;
    vec = d & owned_by(dom);
    if (off == OFF_DOMAINCFG) begin
      m_ie[dom] = d[8];
    end else if (is_cfg(off)) begin
      n = int'(off[15:2]);
      if (!dom) begin
        m_owner[n] = d[10];
        m_mode[n]  = filter_mode(d);
      end else if (m_owner[n]) begin
        m_mode[n] = filter_mode(d);
      end
    end else if (is_tgt(off)) begin
      // Target words start at 0x3004 for source 1
      n = int'(off[15:2] - 14'h0C00);
      if (m_owner[n] == dom && m_mode[n] != SM_INACTIVE) begin
        m_hart[n] = d[31:18];
        m_prio[n] = (d[7:0] == 8'h00) ? 8'h01 : d[7:0];
      end
    end else begin
      case (off)
        OFF_SETIP:    m_pend = m_pend | vec;
        OFF_SETIPNUM: m_pend = m_pend | num_bit(dom, d);
        OFF_IN_CLRIP: m_pend = m_pend & ~vec;
        OFF_CLRIPNUM: m_pend = m_pend & ~num_bit(dom, d);
        OFF_SETIE:    m_en   = m_en | vec;
        OFF_SETIENUM: m_en   = m_en | num_bit(dom, d);
        OFF_CLRIE:    m_en   = m_en & ~vec;
        OFF_CLRIENUM: m_en   = m_en & ~num_bit(dom, d);
        default: ;
      endcase
    end
    drop_inactive();
  endfunction

  function automatic logic [31:0] model_read(input logic dom, input logic [15:0] off);
    int n;
    n = 0;
    if (off == OFF_DOMAINCFG) return m_ie[dom] ? 32'h8000_0100 : 32'h8000_0000;
    if (is_cfg(off)) begin
      n = int'(off[15:2]);
      if (!dom) return m_owner[n] ? 32'h0000_0400 : 32'(m_mode[n]);
      return m_owner[n] ? 32'(m_mode[n]) : 32'h0;
    end
    if (is_tgt(off)) begin
      n = int'(off[15:2] - 14'h0C00);
      return (m_owner[n] == dom) ? {m_hart[n], 10'b0, m_prio[n]} : 32'h0;
    end
    case (off)
      OFF_SETIP, OFF_IN_CLRIP: return m_pend & owned_by(dom);
      OFF_SETIE:               return m_en & owned_by(dom);
      default:                 return 32'h0;
    endcase
  endfunction

  // Expected {priority, id} of the top source in one domain
  function automatic logic [12:0] ref_top(input logic dom);
    logic [31:0] cand;
    logic [7:0]  best;
    int          n;
    cand    = m_pend & m_en & owned_by(dom);
    cand[0] = 1'b0;
    if (!m_ie[dom] || cand == '0) return '0;
    best = 8'hFF;
    for (n = 1; n < NR_SRC; n++) begin
      if (cand[n] && m_prio[n] < best) best = m_prio[n];
    end
    for (n = 1; n < NR_SRC; n++) begin
      if (cand[n] && m_prio[n] == best) return {best, 5'(n)};
    end
    return '0;
  endfunction

  // ============================================================
  // Compare process
  // ============================================================
  function automatic void push_check(input string name, input logic [31:0] got,
                                     input logic [31:0] want);
    name_q.push_back(name);
    got_q.push_back(got);
    want_q.push_back(want);
  endfunction

  always @(negedge i_clk) begin : compare
    string       name;
    logic [31:0] got;
    logic [31:0] want;
    while (name_q.size() > 0) begin
      name = name_q.pop_front();
      got  = got_q.pop_front();
      want = want_q.pop_front();
      checks++;
      assert (got === want)
      else begin
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
        errors++;
      end
    end
  end

  // ============================================================
  // Bus and stimulus tasks
  // ============================================================
  function automatic logic [31:0] reg_adr(input logic dom, input logic [15:0] off);
    return (dom ? BASE_S : BASE_M) | 32'(off);
  endfunction

  function automatic logic [15:0] cfg_off(input int n);
    return OFF_SOURCECFG + 16'(4 * (n - 1));
  endfunction

  function automatic logic [15:0] tgt_off(input int n);
    return OFF_TARGET + 16'(4 * (n - 1));
  endfunction

  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(negedge i_clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    while (!o_wb_ack && waited < ACK_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (o_wb_ack) begin
      rdat = o_wb_dat;
      // The master samples ack on the next rising edge and releases after it
      @(negedge i_clk);
    end else begin
      timeouts++;
      $display("Wishbone ack did not arrive for address 0x%08h", adr);
    end
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic reg_write(input logic dom, input logic [15:0] off, input logic [31:0] d);
    logic [31:0] rdat;
    bus_access(1'b1, reg_adr(dom, off), d, rdat);
    model_write(dom, off, d);
  endtask

  task automatic reg_check(input logic dom, input logic [15:0] off, input string name);
    logic [31:0] rdat;
    bus_access(1'b0, reg_adr(dom, off), 32'h0, rdat);
    push_check($sformatf("o_wb_dat(%s %s)", dom ? "S" : "M", name), rdat,
               model_read(dom, off));
  endtask

  task automatic pulse_sources(input logic [31:0] v);
    @(negedge i_clk);
    i_src_pulse = v;
    @(negedge i_clk);
    i_src_pulse = '0;
    m_pend = m_pend | v;
    drop_inactive();
  endtask

  task automatic check_sourcecfg();
    for (int n = 1; n < NR_SRC; n++) begin
      reg_check(1'b0, cfg_off(n), $sformatf("sourcecfg[%0d]", n));
      reg_check(1'b1, cfg_off(n), $sformatf("sourcecfg[%0d]", n));
    end
  endtask

  task automatic check_pend_enable();
    for (int d = 0; d < NR_DOM; d++) begin
      reg_check(d[0], OFF_SETIP, "setip");
      reg_check(d[0], OFF_IN_CLRIP, "in_clrip");
      reg_check(d[0], OFF_SETIE, "setie");
      reg_check(d[0], OFF_CLRIE, "clrie");
      reg_check(d[0], OFF_SETIPNUM, "setipnum");
    end
  endtask

  // Output register lags the state by one edge
  task automatic check_top();
    logic [12:0] want;
    repeat (2) @(negedge i_clk);
    for (int d = 0; d < NR_DOM; d++) begin
      want = ref_top(d[0]);
      push_check($sformatf("o_top_id[%0d]", d), 32'(o_top_id[d]), 32'(want[4:0]));
      push_check($sformatf("o_top_prio[%0d]", d), 32'(o_top_prio[d]), 32'(want[12:5]));
    end
  endtask

  task automatic end_test(input string title);
    int waited;
    waited = 0;
    while (name_q.size() > 0 && waited < 4) begin
      @(negedge i_clk);
      waited++;
    end
    if (name_q.size() > 0) begin
      timeouts++;
      $display("Compare queue did not drain after %s", title);
    end
    $display("%s: %0d checks, %0d failed", title, checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  // ============================================================
  // Tests
  // ============================================================
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] d;
    logic        dom;
    int          n;
    int          i;
    seed        = 32'h5545_ccda;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    test_checks = 0;
    test_errors = 0;
    ni_rst      = 1'b0;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    i_src_pulse = '0;
    m_owner     = '0;
    m_pend      = '0;
    m_en        = '0;
    m_ie        = '0;
    for (n = 0; n < NR_SRC; n++) begin
      m_mode[n] = SM_INACTIVE;
      m_prio[n] = 8'h00;
      m_hart[n] = 14'h0;
    end
    repeat (8) @(negedge i_clk);
    ni_rst = 1'b1;

    // Reset values and the IE bit
    @(negedge i_clk);
    push_check("o_top_id", 32'(o_top_id), 32'h0);
    push_check("o_top_prio", 32'(o_top_prio), 32'h0);
    reg_check(1'b0, OFF_DOMAINCFG, "domaincfg");
    reg_check(1'b1, OFF_DOMAINCFG, "domaincfg");
    reg_write(1'b0, OFF_DOMAINCFG, 32'hFFFF_FFFF);
    reg_write(1'b1, OFF_DOMAINCFG, 32'hFFFF_FFFF);
    reg_check(1'b0, OFF_DOMAINCFG, "domaincfg");
    reg_check(1'b1, OFF_DOMAINCFG, "domaincfg");
    // An unmapped address is still acknowledged but reads 0 and writes nothing
    bus_access(1'b1, UNMAPPED, 32'h0, r);
    bus_access(1'b0, UNMAPPED, 32'h0, r);
    push_check("o_wb_dat(unmapped)", r, 32'h0);
    reg_check(1'b0, OFF_DOMAINCFG, "domaincfg");
    end_test("Test 1 reset and domaincfg");

    // M delegates sources and S then configures its own
    reg_write(1'b0, cfg_off(1), 32'h0000_0002);
    reg_check(1'b0, cfg_off(1), "sourcecfg[1]");
    for (n = 1; n < NR_SRC; n++) begin
      r = $random(seed);
      reg_write(1'b0, cfg_off(n), r & 32'h0000_0407);
    end
    check_sourcecfg();
    for (n = 1; n < NR_SRC; n++) begin
      r = $random(seed);
      reg_write(1'b1, cfg_off(n), {21'b0, r[10] & r[11], 7'b0, r[2:0]});
    end
    check_sourcecfg();
    end_test("Test 2 delegation");

    // Random set and clear traffic from both domains
    for (i = 0; i < 48; i++) begin
      r   = $random(seed);
      d   = $random(seed);
      dom = r[3];
      if (i % 6 == 5) r[0] = 1'b1;
      if (r[0]) d = (i % 6 == 5) ? 32'd40 : {27'b0, d[4:0]};
      reg_write(dom, PE_OFF[r[2:0]], d);
      check_pend_enable();
    end
    end_test("Test 3 pending and enable");

    for (i = 0; i < 24; i++) begin
      r   = $random(seed);
      d   = $random(seed);
      n   = 1 + int'(r[4:0]) % (NR_SRC - 1);
      dom = (i % 2 == 0) ? m_owner[n] : r[5];
      if (i < 6) d[7:0] = 8'h00;
      reg_write(dom, tgt_off(n), d);
      reg_check(1'b0, tgt_off(n), $sformatf("target[%0d]", n));
      reg_check(1'b1, tgt_off(n), $sformatf("target[%0d]", n));
    end
    end_test("Test 4 target");

    reg_write(1'b0, OFF_IN_CLRIP, 32'hFFFF_FFFF);
    reg_write(1'b1, OFF_IN_CLRIP, 32'hFFFF_FFFF);
    for (i = 0; i < 8; i++) begin
      r = $random(seed);
      d = $random(seed);
      pulse_sources(r & d);
      reg_check(1'b0, OFF_SETIP, "setip");
      reg_check(1'b1, OFF_SETIP, "setip");
    end
    end_test("Test 5 gateway pulse");

    // Delivery is off in M for round 0 and in S for round 1
    for (i = 0; i < 10; i++) begin
      for (n = 1; n < NR_SRC; n++) begin
        r = $random(seed);
        reg_write(1'b0, cfg_off(n), r & 32'h0000_0407);
        if (m_owner[n]) reg_write(1'b1, cfg_off(n), {29'b0, r[6:4]});
        reg_write(m_owner[n], tgt_off(n), {r[31:18], 15'b0, r[9:7]});
      end
      reg_write(1'b0, OFF_DOMAINCFG, (i == 0) ? 32'h0 : 32'h100);
      reg_write(1'b1, OFF_DOMAINCFG, (i == 1) ? 32'h0 : 32'h100);
      for (n = 0; n < NR_DOM; n++) begin
        r = $random(seed);
        d = $random(seed);
        reg_write(n[0], OFF_SETIE, r | d);
        reg_write(n[0], OFF_IN_CLRIP, 32'hFFFF_FFFF);
        reg_write(n[0], OFF_SETIP, r & d);
      end
      check_top();
      r = $random(seed);
      pulse_sources(r);
      check_top();
    end
    end_test("Test 6 top selection");

    $display("Total: %0d checks, %0d failed, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* all.f */
source/aplic_pkg.sv
source/aplic_wb_port.sv
source/aplic_config_regs.sv
source/aplic_pend_enable.sv
source/aplic_top_select.sv
source/aplic_domain_top.sv
verif/aplic_asserts.sv
verif/aplic_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module aplic_tb -f all.f -o aplic_sim \
  > build.log 2>&1 \
  && ./obj_dir/aplic_sim > sim.log 2>&1 \
  || echo "Build or simulation stopped early, see build.log and sim.log"
grep -q "^No errors$" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
